// File: Makefile
# Verilator build and run for the GAT memory controller testbench
# Any variable can be overridden on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_mem_ctrl_top
FILELIST  ?= mem_ctrl_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= NO ERRORS

SIM_BIN  = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(wildcard hdl/*.sv verification/*.sv verification/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$($(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/feat_store.sv
// Feature store
// New-feature memory that a layer writes its results into. The conv1
// engine owns the write port in layer 0, the conv2 engine in layer 1.

`timescale 1ns/100ps

module feat_store
  import gat_mem_cfg_pkg::*, gat_mem_types_pkg::*;
(
  input  logic                   clk,
  input  logic                   gat_layer,
  input  feat_wr_t               conv1_feat_wr,
  input  feat_wr_t               conv2_feat_wr,
  input  logic                   feat_rd_en,
  input  logic [FEAT_ADDR_W-1:0] feat_rd_addr,
  output logic [FEAT_WIDTH-1:0]  feat_rd_data
);

  feat_wr_t feat_wr;

  // Inactive engine's writes are dropped
  assign feat_wr = gat_layer ? conv2_feat_wr : conv1_feat_wr;

  ram_1r1w #(
    .WIDTH (FEAT_WIDTH),
    .DEPTH (FEAT_DEPTH)
  ) u_feat_ram (
    .clk   (clk),
    .we    (feat_wr.en),
    .waddr (feat_wr.addr),
    .wdata (feat_wr.data),
    .re    (feat_rd_en),
    .raddr (feat_rd_addr),
    .rdata (feat_rd_data)
  );

endmodule

// File: hdl/gat_mem_cfg_pkg.sv
// GAT memory system configuration
// Depths, field widths and address widths shared by the on-chip
// memories and the read path. Sizes are at simulation scale.

package gat_mem_cfg_pkg;

  // ====================================================================
  // Feature and graph sizes
  // ====================================================================
  localparam int DATA_WIDTH       = 8;
  localparam int NUM_FEATURE_IN   = 16;
  localparam int MAX_NODES        = 8;

  // Sparse H entry fields
  localparam int COL_IDX_WIDTH    = $clog2(NUM_FEATURE_IN);
  localparam int H_ENTRY_W        = DATA_WIDTH + COL_IDX_WIDTH;

  // Node info fields, flag is a single bit
  localparam int NUM_NODE_WIDTH   = $clog2(MAX_NODES);
  localparam int ROW_LEN_WIDTH    = $clog2(NUM_FEATURE_IN);
  localparam int NODE_INFO_W      = ROW_LEN_WIDTH + NUM_NODE_WIDTH + 1;

  // ====================================================================
  // Memory depths and address widths
  // ====================================================================
  localparam int H_DATA_DEPTH     = 64;
  localparam int H_DATA_ADDR_W    = $clog2(H_DATA_DEPTH);
  localparam int NODE_INFO_DEPTH  = 16;
  localparam int NODE_INFO_ADDR_W = $clog2(NODE_INFO_DEPTH);
  localparam int FEAT_DEPTH       = 32;
  localparam int FEAT_ADDR_W      = $clog2(FEAT_DEPTH);
  localparam int FEAT_WIDTH       = 32;

  // Read stream, address sized for the widest memory
  localparam int RD_WORD_W        = 32;
  localparam int RD_ADDR_W        =
    (H_DATA_ADDR_W >= NODE_INFO_ADDR_W && H_DATA_ADDR_W >= FEAT_ADDR_W) ? H_DATA_ADDR_W :
    (NODE_INFO_ADDR_W >= FEAT_ADDR_W) ? NODE_INFO_ADDR_W : FEAT_ADDR_W;

endpackage

// File: hdl/gat_mem_types_pkg.sv
// GAT memory system types
// Write port structs, read request and response structs, the target
// encoding and the response word with its three decoded views.

package gat_mem_types_pkg;
  import gat_mem_cfg_pkg::*;

  // One sparse H entry, zero padded up to a response word
  typedef struct packed {
    logic [RD_WORD_W-H_ENTRY_W-1:0] pad;
    logic [DATA_WIDTH-1:0]          value;
    logic [COL_IDX_WIDTH-1:0]       col_idx;
  } h_entry_t;

  // Per-node information word
  typedef struct packed {
    logic [RD_WORD_W-NODE_INFO_W-1:0] pad;
    logic [ROW_LEN_WIDTH-1:0]         row_len;
    logic [NUM_NODE_WIDTH-1:0]        num_node;
    logic                             flag;
  } node_info_t;

  // Same response word seen as H entry, node info or raw feature
  typedef union packed {
    h_entry_t             h;
    node_info_t           node;
    logic [RD_WORD_W-1:0] feat;
  } rd_word_u;

  typedef enum logic [1:0] {
    H_DATA    = 2'd0,
    NODE_INFO = 2'd1,
    FEAT      = 2'd2
  } rd_target_e;

  // ====================================================================
  // Write ports
  // ====================================================================
  typedef struct packed {
    logic                     en;
    logic [H_DATA_ADDR_W-1:0] addr;
    h_entry_t                 entry;
  } h_wr_t;

  typedef struct packed {
    logic                        en;
    logic [NODE_INFO_ADDR_W-1:0] addr;
    node_info_t                  info;
  } node_wr_t;

  typedef struct packed {
    logic                   en;
    logic [FEAT_ADDR_W-1:0] addr;
    logic [FEAT_WIDTH-1:0]  data;
  } feat_wr_t;

  // ====================================================================
  // Read stream
  // ====================================================================
  typedef struct packed {
    rd_target_e             target;
    logic [RD_ADDR_W-1:0]   addr;
  } rd_req_t;

  typedef struct packed {
    rd_target_e target;
    rd_word_u   word;
  } rd_rsp_t;

endpackage

// File: hdl/h_store.sv
// H store
// Sparse H data memory and node-info memory. H data is written by the
// feature writeback path while layer 0 runs with new features ready,
// and by the processor load port at all other times.

`timescale 1ns/100ps

module h_store
  import gat_mem_cfg_pkg::*, gat_mem_types_pkg::*;
(
  input  logic                        clk,
  input  logic                        gat_layer,
  input  logic                        new_feat_rdy,
  input  h_wr_t                       ps_h_wr,
  input  h_wr_t                       fb_h_wr,
  input  node_wr_t                    ps_node_wr,
  input  logic                        h_rd_en,
  input  logic [H_DATA_ADDR_W-1:0]    h_rd_addr,
  input  logic                        node_rd_en,
  input  logic [NODE_INFO_ADDR_W-1:0] node_rd_addr,
  output h_entry_t                    h_rd_data,
  output node_info_t                  node_rd_data
);

  h_wr_t                  h_wr;
  logic [H_ENTRY_W-1:0]   h_raw;
  logic [NODE_INFO_W-1:0] node_raw;

  // Writeback owns the H port only in layer 0 with new features ready
  assign h_wr = (!gat_layer && new_feat_rdy) ? fb_h_wr : ps_h_wr;

  // ====================================================================
  // Memories, only the live fields are stored
  // ====================================================================
  ram_1r1w #(
    .WIDTH (H_ENTRY_W),
    .DEPTH (H_DATA_DEPTH)
  ) u_h_data_ram (
    .clk   (clk),
    .we    (h_wr.en),
    .waddr (h_wr.addr),
    .wdata ({h_wr.entry.value, h_wr.entry.col_idx}),
    .re    (h_rd_en),
    .raddr (h_rd_addr),
    .rdata (h_raw)
  );

  ram_1r1w #(
    .WIDTH (NODE_INFO_W),
    .DEPTH (NODE_INFO_DEPTH)
  ) u_node_info_ram (
    .clk   (clk),
    .we    (ps_node_wr.en),
    .waddr (ps_node_wr.addr),
    .wdata ({ps_node_wr.info.row_len, ps_node_wr.info.num_node, ps_node_wr.info.flag}),
    .re    (node_rd_en),
    .raddr (node_rd_addr),
    .rdata (node_raw)
  );

  // Rebuild the padded words, pad bits read as zero
  always_comb begin
    h_rd_data         = '0;
    h_rd_data.value   = h_raw[H_ENTRY_W-1 -: DATA_WIDTH];
    h_rd_data.col_idx = h_raw[COL_IDX_WIDTH-1:0];

    node_rd_data          = '0;
    node_rd_data.row_len  = node_raw[NODE_INFO_W-1 -: ROW_LEN_WIDTH];
    node_rd_data.num_node = node_raw[NUM_NODE_WIDTH:1];
    node_rd_data.flag     = node_raw[0];
  end

endmodule

// File: hdl/mem_ctrl_top.sv
// GAT memory controller top
// H data and node-info store, new-feature store and the read merge
// that serves all reads through one request and response stream.

`timescale 1ns/100ps

module mem_ctrl_top
  import gat_mem_cfg_pkg::*, gat_mem_types_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     gat_layer,
  input  logic     new_feat_rdy,
  input  h_wr_t    ps_h_wr,
  input  h_wr_t    fb_h_wr,
  input  node_wr_t ps_node_wr,
  input  feat_wr_t conv1_feat_wr,
  input  feat_wr_t conv2_feat_wr,
  input  logic     req_valid,
  output logic     req_ready,
  input  rd_req_t  req,
  output logic     rsp_valid,
  input  logic     rsp_ready,
  output rd_rsp_t  rsp
);

  logic                        h_rd_en;
  logic [H_DATA_ADDR_W-1:0]    h_rd_addr;
  h_entry_t                    h_rd_data;
  logic                        node_rd_en;
  logic [NODE_INFO_ADDR_W-1:0] node_rd_addr;
  node_info_t                  node_rd_data;
  logic                        feat_rd_en;
  logic [FEAT_ADDR_W-1:0]      feat_rd_addr;
  logic [FEAT_WIDTH-1:0]       feat_rd_data;

  // ====================================================================
  // Stores
  // ====================================================================
  h_store u_h_store (
    .clk          (clk),
    .gat_layer    (gat_layer),
    .new_feat_rdy (new_feat_rdy),
    .ps_h_wr      (ps_h_wr),
    .fb_h_wr      (fb_h_wr),
    .ps_node_wr   (ps_node_wr),
    .h_rd_en      (h_rd_en),
    .h_rd_addr    (h_rd_addr),
    .node_rd_en   (node_rd_en),
    .node_rd_addr (node_rd_addr),
    .h_rd_data    (h_rd_data),
    .node_rd_data (node_rd_data)
  );

  feat_store u_feat_store (
    .clk           (clk),
    .gat_layer     (gat_layer),
    .conv1_feat_wr (conv1_feat_wr),
    .conv2_feat_wr (conv2_feat_wr),
    .feat_rd_en    (feat_rd_en),
    .feat_rd_addr  (feat_rd_addr),
    .feat_rd_data  (feat_rd_data)
  );

  // Read path
  read_merge u_read_merge (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .req          (req),
    .rsp_valid    (rsp_valid),
    .rsp_ready    (rsp_ready),
    .rsp          (rsp),
    .h_rd_en      (h_rd_en),
    .h_rd_addr    (h_rd_addr),
    .node_rd_en   (node_rd_en),
    .node_rd_addr (node_rd_addr),
    .feat_rd_en   (feat_rd_en),
    .feat_rd_addr (feat_rd_addr),
    .h_rd_data    (h_rd_data),
    .node_rd_data (node_rd_data),
    .feat_rd_data (feat_rd_data)
  );

endmodule

// File: hdl/ram_1r1w.sv
// Generic synchronous memory
// One write port and one registered read port. A read and a write to
// the same address at one edge return the old contents. The read
// register holds its value while re is low.

`timescale 1ns/100ps

module ram_1r1w #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  logic [WIDTH-1:0]         wdata,
  input  logic                     re,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output logic [WIDTH-1:0]         rdata
);

  logic [WIDTH-1:0] mem [DEPTH];

  // Nonblocking read sees the array before this edge's write
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

// File: hdl/read_merge.sv
// Read merge
// Takes one valid/ready request stream, sends each request to its
// target memory and returns the data as one tagged response stream.
// The accepting edge reads the memory, the next edge loads the output
// register. Both stages stall together under back-pressure.

`timescale 1ns/100ps

module read_merge
  import gat_mem_cfg_pkg::*, gat_mem_types_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req_valid,
  output logic                        req_ready,
  input  rd_req_t                     req,
  output logic                        rsp_valid,
  input  logic                        rsp_ready,
  output rd_rsp_t                     rsp,
  output logic                        h_rd_en,
  output logic [H_DATA_ADDR_W-1:0]    h_rd_addr,
  output logic                        node_rd_en,
  output logic [NODE_INFO_ADDR_W-1:0] node_rd_addr,
  output logic                        feat_rd_en,
  output logic [FEAT_ADDR_W-1:0]      feat_rd_addr,
  input  h_entry_t                    h_rd_data,
  input  node_info_t                  node_rd_data,
  input  logic [FEAT_WIDTH-1:0]       feat_rd_data
);

  logic       req_fire;
  logic       m_valid;
  rd_target_e m_target;
  rd_word_u   rsp_word;

  // ====================================================================
  // Dispatch
  // ====================================================================
  // Whole pipeline moves whenever the output stage can drain
  assign req_ready = !rsp_valid || rsp_ready;
  assign req_fire  = req_valid && req_ready;

  assign h_rd_en    = req_fire && (req.target == H_DATA);
  assign node_rd_en = req_fire && (req.target == NODE_INFO);
  assign feat_rd_en = req_fire && (req.target == FEAT);

  assign h_rd_addr    = req.addr[H_DATA_ADDR_W-1:0];
  assign node_rd_addr = req.addr[NODE_INFO_ADDR_W-1:0];
  assign feat_rd_addr = req.addr[FEAT_ADDR_W-1:0];

  // ====================================================================
  // Memory stage and output stage
  // ====================================================================
  // Pick the view of the returning memory
  always_comb begin
    rsp_word = '0;
    case (m_target)
      H_DATA:    rsp_word.h    = h_rd_data;
      NODE_INFO: rsp_word.node = node_rd_data;
      FEAT:      rsp_word.feat = feat_rd_data;
      default:   rsp_word      = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid   <= 1'b0;
      rsp_valid <= 1'b0;
    end else if (req_ready) begin
      m_valid   <= req_fire;
      rsp_valid <= m_valid;
    end
  end

  // Memory read data holds while stalled, since no new read is issued
  always_ff @(posedge clk) begin
    if (req_fire) begin
      m_target <= req.target;
    end
    if (req_ready && m_valid) begin
      rsp.target <= m_target;
      rsp.word   <= rsp_word;
    end
  end

endmodule

// File: mem_ctrl_top.f
+incdir+verification
hdl/gat_mem_cfg_pkg.sv
hdl/gat_mem_types_pkg.sv
hdl/ram_1r1w.sv
hdl/h_store.sv
hdl/feat_store.sv
hdl/read_merge.sv
hdl/mem_ctrl_top.sv
verification/tb_mem_ctrl_top.sv

// File: verification/mem_model.svh
// Reference model for the GAT memory controller testbench
// Mirrors of the three memories, the xorshift generator and the
// compare tasks for each kind of response.

`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

logic [31:0]           rng_state;
h_entry_t              h_mem    [H_DATA_DEPTH];
node_info_t            node_mem [NODE_INFO_DEPTH];
logic [FEAT_WIDTH-1:0] feat_mem [FEAT_DEPTH];

// xorshift32 step
function automatic logic [31:0] next_rand();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// Expected response word, unused bits zero
function automatic rd_rsp_t model_read(rd_req_t r);
  rd_rsp_t e;
  e        = '0;
  e.target = r.target;
  case (r.target)
    H_DATA:    e.word.h    = h_mem[r.addr[H_DATA_ADDR_W-1:0]];
    NODE_INFO: e.word.node = node_mem[r.addr[NODE_INFO_ADDR_W-1:0]];
    default:   e.word.feat = feat_mem[r.addr[FEAT_ADDR_W-1:0]];
  endcase
  return e;
endfunction

// Writeback owns H only in layer 0 with new features ready
task automatic model_write();
  h_wr_t      h_src;
  feat_wr_t   f_src;
  h_entry_t   h_val;
  node_info_t n_val;
  h_src = (!gat_layer && new_feat_rdy) ? fb_h_wr : ps_h_wr;
  f_src = gat_layer ? conv2_feat_wr : conv1_feat_wr;
  if (h_src.en) begin
    h_val               = '0;
    h_val.value         = h_src.entry.value;
    h_val.col_idx       = h_src.entry.col_idx;
    h_mem[h_src.addr]   = h_val;
  end
  if (ps_node_wr.en) begin
    n_val                     = '0;
    n_val.row_len             = ps_node_wr.info.row_len;
    n_val.num_node            = ps_node_wr.info.num_node;
    n_val.flag                = ps_node_wr.info.flag;
    node_mem[ps_node_wr.addr] = n_val;
  end
  if (f_src.en) begin
    feat_mem[f_src.addr] = f_src.data;
  end
endtask

// ======================================================================
// Compare tasks
// ======================================================================
task automatic check_h_entry(string name, h_entry_t exp, h_entry_t act);
  if (act !== exp) begin
    $display("FAIL %s h_entry expected %h actual %h", name, exp, act);
    abort_run();
  end
endtask

task automatic check_node_info(string name, node_info_t exp, node_info_t act);
  if (act !== exp) begin
    $display("FAIL %s node_info expected %h actual %h", name, exp, act);
    abort_run();
  end
endtask

task automatic check_feat(string name, logic [FEAT_WIDTH-1:0] exp, logic [FEAT_WIDTH-1:0] act);
  if (act !== exp) begin
    $display("FAIL %s feat expected %h actual %h", name, exp, act);
    abort_run();
  end
endtask

task automatic check_latency(string name, int unsigned exp, int unsigned act);
  if (act != exp) begin
    $display("FAIL %s response cycle expected %0d actual %0d", name, exp, act);
    abort_run();
  end
endtask

task automatic check_ready(string name, logic exp, logic act);
  if (act !== exp) begin
    $display("FAIL %s req_ready expected %b actual %b", name, exp, act);
    abort_run();
  end
endtask

task automatic check_response(rd_rsp_t exp, rd_rsp_t act);
  if (act.target !== exp.target) begin
    $display("Response carries target %0d but the request was for target %0d",
             act.target, exp.target);
    abort_run();
  end
  case (exp.target)
    H_DATA:    check_h_entry(test_name, exp.word.h, act.word.h);
    NODE_INFO: check_node_info(test_name, exp.word.node, act.word.node);
    default:   check_feat(test_name, exp.word.feat, act.word.feat);
  endcase
endtask

`endif

// File: verification/tb_mem_ctrl_top.sv
// Testbench for the GAT memory controller top
// Loads all memories over the write ports, reads them back, then runs
// random writes and reads under random back-pressure. Every response
// is checked against a model for data, order and latency.

`timescale 1ns/100ps

module tb_mem_ctrl_top
  import gat_mem_cfg_pkg::*, gat_mem_types_pkg::*;
();

  localparam logic [31:0] SEED = 32'h0a67e299;
  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 16;
  localparam int READBACK_LEN  = H_DATA_DEPTH + NODE_INFO_DEPTH + FEAT_DEPTH;
  localparam int RANDOM_CYCLES = 800;
  localparam int DRAIN_CYCLES  = 16;
  localparam int TOTAL_CYCLES  =
    RESET_CYCLES + H_DATA_DEPTH + READBACK_LEN + RANDOM_CYCLES + DRAIN_CYCLES;

  typedef struct packed {
    rd_rsp_t     rsp;
    logic [31:0] cycle;
    logic [31:0] stalls;
  } exp_rsp_t;

  logic     clk;
  logic     rst_n;
  logic     gat_layer;
  logic     new_feat_rdy;
  h_wr_t    ps_h_wr;
  h_wr_t    fb_h_wr;
  node_wr_t ps_node_wr;
  feat_wr_t conv1_feat_wr;
  feat_wr_t conv2_feat_wr;
  logic     req_valid;
  logic     req_ready;
  rd_req_t  req;
  logic     rsp_valid;
  logic     rsp_ready;
  rd_rsp_t  rsp;

  exp_rsp_t    exp_q [$];
  string       test_name;
  logic [31:0] cycle_cnt;
  logic [31:0] stall_cnt;
  logic        hold_pending;
  rd_rsp_t     held_rsp;
  logic        mem_busy;
  logic        out_busy;

  `include "mem_model.svh"

  mem_ctrl_top i_dut (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic clear_inputs();
    gat_layer     = 1'b0;
    new_feat_rdy  = 1'b0;
    ps_h_wr       = '0;
    fb_h_wr       = '0;
    ps_node_wr    = '0;
    conv1_feat_wr = '0;
    conv2_feat_wr = '0;
    req_valid     = 1'b0;
    req           = '0;
    rsp_ready     = 1'b0;
  endtask

  task automatic randomize_inputs();
    logic [31:0] r;
    r                = next_rand();
    gat_layer        = r[0];
    new_feat_rdy     = r[1];
    req_valid        = (r[4:2] != 3'd0);
    rsp_ready        = (r[6:5] != 2'd0);
    req.target       = (r[8:7] == 2'd3) ? H_DATA : rd_target_e'(r[8:7]);
    req.addr         = r[9 +: RD_ADDR_W];
    ps_h_wr.en       = r[15];
    fb_h_wr.en       = r[16];
    ps_node_wr.en    = r[17];
    conv1_feat_wr.en = r[18];
    conv2_feat_wr.en = r[19];
    r                  = next_rand();
    ps_h_wr.addr       = r[0 +: H_DATA_ADDR_W];
    fb_h_wr.addr       = r[8 +: H_DATA_ADDR_W];
    ps_node_wr.addr    = r[16 +: NODE_INFO_ADDR_W];
    conv1_feat_wr.addr = r[20 +: FEAT_ADDR_W];
    conv2_feat_wr.addr = r[25 +: FEAT_ADDR_W];
    // Half the cycles write where the request reads
    if (r[31]) begin
      ps_h_wr.addr       = req.addr[H_DATA_ADDR_W-1:0];
      fb_h_wr.addr       = req.addr[H_DATA_ADDR_W-1:0];
      ps_node_wr.addr    = req.addr[NODE_INFO_ADDR_W-1:0];
      conv1_feat_wr.addr = req.addr[FEAT_ADDR_W-1:0];
      conv2_feat_wr.addr = req.addr[FEAT_ADDR_W-1:0];
    end
    ps_h_wr.entry      = h_entry_t'(next_rand());
    fb_h_wr.entry      = h_entry_t'(next_rand());
    ps_node_wr.info    = node_info_t'(next_rand());
    conv1_feat_wr.data = next_rand();
    conv2_feat_wr.data = next_rand();
  endtask

  // ====================================================================
  // Response checks, then model read, then model write at each edge
  // ====================================================================
  always @(posedge clk) begin
    exp_rsp_t e;
    logic     exp_ready;
    if (rst_n) begin
      cycle_cnt = cycle_cnt + 1;
      // Two-stage pipeline, the output stage drains on rsp_ready
      exp_ready = !out_busy || rsp_ready;
      check_ready(test_name, exp_ready, req_ready);
      if (exp_ready) begin
        out_busy = mem_busy;
        mem_busy = req_valid;
      end
      if (hold_pending && (!rsp_valid || rsp !== held_rsp)) begin
        $display("Response changed or vanished while held by back-pressure");
        abort_run();
      end
      hold_pending = rsp_valid && !rsp_ready;
      held_rsp     = rsp;
      if (rsp_valid && rsp_ready) begin
        if (exp_q.size() == 0) begin
          $display("Response arrived with no request outstanding");
          abort_run();
        end else begin
          e = exp_q.pop_front();
          check_response(e.rsp, rsp);
          // Exact latency holds only for an unstalled pipeline
          if (e.stalls == stall_cnt) begin
            check_latency(test_name, e.cycle + 32'd2, cycle_cnt);
          end
        end
      end
      if (!req_ready) begin
        stall_cnt = stall_cnt + 1;
      end
      if (req_valid && req_ready) begin
        e.rsp    = model_read(req);
        e.cycle  = cycle_cnt;
        e.stalls = stall_cnt;
        exp_q.push_back(e);
      end
      model_write();
    end
  end

  initial begin
    #(TOTAL_CYCLES * CLK_PERIOD * 4);
    $display("Timeout, run did not finish within %0d cycles", TOTAL_CYCLES * 4);
    abort_run();
  end

  initial begin
    rng_state    = SEED;
    cycle_cnt    = '0;
    stall_cnt    = '0;
    hold_pending = 1'b0;
    held_rsp     = '0;
    mem_busy     = 1'b0;
    out_busy     = 1'b0;
    rst_n        = 1'b0;
    clear_inputs();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Fill every address, the inactive sources write too
    test_name = "ps_load";
    for (int a = 0; a < H_DATA_DEPTH; a++) begin
      randomize_inputs();
      req_valid          = 1'b0;
      gat_layer          = (a >= H_DATA_DEPTH / 2);
      new_feat_rdy       = new_feat_rdy & gat_layer;
      ps_h_wr.en         = 1'b1;
      ps_h_wr.addr       = a[H_DATA_ADDR_W-1:0];
      ps_node_wr.en      = 1'b1;
      ps_node_wr.addr    = a[NODE_INFO_ADDR_W-1:0];
      conv1_feat_wr.en   = 1'b1;
      conv1_feat_wr.addr = a[FEAT_ADDR_W-1:0];
      conv2_feat_wr.en   = 1'b1;
      conv2_feat_wr.addr = a[FEAT_ADDR_W-1:0];
      @(negedge clk);
    end

    test_name = "readback";
    for (int i = 0; i < READBACK_LEN; i++) begin
      clear_inputs();
      req_valid = 1'b1;
      rsp_ready = 1'b1;
      if (i < H_DATA_DEPTH) begin
        req.target = H_DATA;
        req.addr   = RD_ADDR_W'(i);
      end else if (i < H_DATA_DEPTH + NODE_INFO_DEPTH) begin
        req.target = NODE_INFO;
        req.addr   = RD_ADDR_W'(i - H_DATA_DEPTH);
      end else begin
        req.target = FEAT;
        req.addr   = RD_ADDR_W'(i - H_DATA_DEPTH - NODE_INFO_DEPTH);
      end
      @(negedge clk);
    end

    test_name = "random_mix";
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      randomize_inputs();
      @(negedge clk);
    end

    test_name = "drain";
    clear_inputs();
    rsp_ready = 1'b1;
    for (int d = 0; d < DRAIN_CYCLES && exp_q.size() != 0; d++) begin
      @(negedge clk);
    end
    if (exp_q.size() != 0) begin
      $display("%0d responses never arrived", exp_q.size());
      abort_run();
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule
